// File: design/eth_pkg.sv
`default_nettype none

package eth_pkg;

    // One byte of the frame stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } byte_beat_t;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;

    typedef struct packed {
        mac_addr_t   dst_mac;
        mac_addr_t   src_mac;
        logic [15:0] ethertype;
    } eth_hdr_t;

    // IPv4 header without options, fields in wire order
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [15:0] ident;
        logic [2:0]  flags;
        logic [12:0] frag_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] checksum;
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
    } ipv4_hdr_t;

    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // Byte 0 on the wire sits in the top eight bits
    typedef struct packed {
        eth_hdr_t  eth;
        ipv4_hdr_t ip;
        udp_hdr_t  udp;
    } frame_hdr_t;

    localparam int          HDR_BYTES      = 42;
    localparam int          UDP_HDR_BYTES  = 8;
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
    localparam logic [3:0]  IP_VERSION4    = 4'd4;
    localparam logic [3:0]  IP_IHL_MIN     = 4'd5;

endpackage

`default_nettype wire

// File: design/echo_cfg_pkg.sv
`default_nettype none

package echo_cfg_pkg;

    // Node identity
    localparam logic [47:0] LOCAL_MAC = 48'h00_60_D7_C0_FF_EE;
    localparam logic [31:0] LOCAL_IP  = {8'd192, 8'd168, 8'd0, 8'd3};

    // Echo service
    localparam logic [15:0] ECHO_PORT = 16'd1234;
    localparam logic [7:0]  REPLY_TTL = 8'd64;

    // Payload buffer, sized for the largest frame
    localparam int FIFO_DEPTH = 2048;
    localparam int FIFO_AW    = 11;

endpackage

`default_nettype wire

// File: design/frame_header_parser.sv
`timescale 1ns/1ps
`default_nettype none

module frame_header_parser (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  eth_pkg::byte_beat_t in_beat,
    output logic                hdr_valid,
    output eth_pkg::frame_hdr_t hdr,
    output logic                pay_valid,
    output eth_pkg::byte_beat_t pay_beat
);
    import eth_pkg::*;

    // Byte offset in the frame, held at HDR_BYTES during payload
    logic [5:0] byte_cnt;
    logic       in_hdr;
    logic       hdr_done;

    assign in_hdr   = byte_cnt < 6'(HDR_BYTES);
    assign hdr_done = byte_cnt == 6'(HDR_BYTES - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt  <= '0;
            hdr_valid <= 1'b0;
            pay_valid <= 1'b0;
        end else begin
            // A 42 byte frame still reports its header
            hdr_valid <= in_valid && hdr_done;
            pay_valid <= in_valid && !in_hdr;
            if (in_valid) begin
                if (in_beat.last) begin
                    // Frame end, also drops a short header silently
                    byte_cnt <= '0;
                end else if (in_hdr) begin
                    byte_cnt <= byte_cnt + 6'd1;
                end
            end
        end
    end

    // Header bytes enter at the bottom and move up
    always_ff @(posedge clk) begin
        if (in_valid && in_hdr) begin
            hdr <= frame_hdr_t'({hdr[$bits(frame_hdr_t)-9:0], in_beat.data});
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && !in_hdr) begin
            pay_beat <= in_beat;
        end
    end

endmodule

`default_nettype wire

// File: design/echo_filter.sv
`timescale 1ns/1ps
`default_nettype none

module echo_filter (
    input  logic                clk,
    input  logic                rst,
    input  logic                hdr_valid,
    input  eth_pkg::frame_hdr_t hdr,
    input  logic                pay_valid,
    input  eth_pkg::byte_beat_t pay_beat,
    output logic                echo_valid,
    output eth_pkg::frame_hdr_t echo_hdr,
    output logic                fwd_valid,
    output eth_pkg::byte_beat_t fwd_beat
);
    import eth_pkg::*;
    import echo_cfg_pkg::*;

    logic match;
    // Decision for the frame whose payload is arriving
    logic match_reg;

    assign match = (hdr.eth.ethertype == ETHERTYPE_IPV4) &&
                   (hdr.ip.version == IP_VERSION4) &&
                   (hdr.ip.ihl == IP_IHL_MIN) &&
                   (hdr.ip.protocol == IP_PROTO_UDP) &&
                   (hdr.ip.dst_ip == LOCAL_IP) &&
                   (hdr.udp.dst_port == ECHO_PORT);

    always_ff @(posedge clk) begin
        if (rst) begin
            echo_valid <= 1'b0;
            fwd_valid  <= 1'b0;
            match_reg  <= 1'b0;
        end else begin
            echo_valid <= hdr_valid && match;
            fwd_valid  <= pay_valid && match_reg;
            if (hdr_valid) begin
                match_reg <= match;
            end else if (pay_valid && pay_beat.last) begin
                match_reg <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_valid) begin
            echo_hdr <= hdr;
        end
        if (pay_valid) begin
            fwd_beat <= pay_beat;
        end
    end

endmodule

`default_nettype wire

// File: design/reply_header_builder.sv
`timescale 1ns/1ps
`default_nettype none

module reply_header_builder (
    input  logic                clk,
    input  logic                rst,
    input  logic                echo_valid,
    input  eth_pkg::frame_hdr_t echo_hdr,
    output logic                reply_valid,
    output eth_pkg::frame_hdr_t reply_hdr
);
    import eth_pkg::*;
    import echo_cfg_pkg::*;

    frame_hdr_t     rep;
    logic [159:0]   ip_words;
    logic [19:0]    sum;
    logic [16:0]    fold1;
    logic [15:0]    fold2;

    always_comb begin
        rep = echo_hdr;
        rep.eth.dst_mac   = echo_hdr.eth.src_mac;
        rep.eth.src_mac   = echo_hdr.eth.dst_mac;
        rep.ip.dscp        = '0;
        rep.ip.ecn         = '0;
        rep.ip.ident       = '0;
        rep.ip.flags       = '0;
        rep.ip.frag_offset = '0;
        rep.ip.ttl         = REPLY_TTL;
        rep.ip.checksum    = '0;
        rep.ip.src_ip      = echo_hdr.ip.dst_ip;
        rep.ip.dst_ip      = echo_hdr.ip.src_ip;
        rep.udp.src_port  = echo_hdr.udp.dst_port;
        rep.udp.dst_port  = echo_hdr.udp.src_port;
        rep.udp.checksum  = '0;

        // Ones' complement sum over ten words, checksum field still zero
        ip_words = rep.ip;
        sum = '0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + 20'(ip_words[16*i +: 16]);
        end
        fold1 = {1'b0, sum[15:0]} + 17'(sum[19:16]);
        fold2 = fold1[15:0] + 16'(fold1[16]);
        rep.ip.checksum = ~fold2;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reply_valid <= 1'b0;
        end else begin
            reply_valid <= echo_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (echo_valid) begin
            reply_hdr <= rep;
        end
    end

endmodule

`default_nettype wire

// File: design/payload_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module payload_fifo (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr_valid,
    input  eth_pkg::byte_beat_t wr_beat,
    input  logic                rd_pop,
    output eth_pkg::byte_beat_t rd_beat,
    output logic                empty
);
    import eth_pkg::*;
    import echo_cfg_pkg::*;

    byte_beat_t       mem [FIFO_DEPTH];
    // Extra top bit tells full from empty
    logic [FIFO_AW:0] wr_ptr;
    logic [FIFO_AW:0] rd_ptr;
    logic             full;

    assign empty   = wr_ptr == rd_ptr;
    assign full    = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                     (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
    assign rd_beat = mem[rd_ptr[FIFO_AW-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_valid && !full) wr_ptr <= wr_ptr + 1'b1;
            if (rd_pop && !empty) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid && !full) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= wr_beat;
        end
    end

endmodule

`default_nettype wire

// File: design/frame_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_serializer (
    input  logic                clk,
    input  logic                rst,
    input  logic                reply_valid,
    input  eth_pkg::frame_hdr_t reply_hdr,
    input  eth_pkg::byte_beat_t fifo_beat,
    input  logic                fifo_empty,
    output logic                fifo_pop,
    output logic                out_valid,
    output eth_pkg::byte_beat_t out_beat,
    output logic [7:0]          led
);
    import eth_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_HDR, S_PAY} state_t;

    state_t     state;
    // Two entry header queue
    frame_hdr_t q_hdr [2];
    logic       q_wr;
    logic       q_rd;
    logic [1:0] q_cnt;
    logic       q_push;
    logic       q_pop;
    frame_hdr_t cur_hdr;
    logic [5:0] byte_idx;
    logic       hdr_end;
    logic       no_pay;
    logic       first_pay;

    assign q_push   = reply_valid && (q_cnt != 2'd2);
    assign q_pop    = (state == S_IDLE) && (q_cnt != 2'd0);
    assign fifo_pop = (state == S_PAY) && !fifo_empty;
    assign hdr_end  = byte_idx == 6'(HDR_BYTES - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            q_wr  <= 1'b0;
            q_rd  <= 1'b0;
            q_cnt <= '0;
        end else begin
            if (q_push) q_wr <= ~q_wr;
            if (q_pop) q_rd <= ~q_rd;
            case ({q_push, q_pop})
                2'b10:   q_cnt <= q_cnt + 2'd1;
                2'b01:   q_cnt <= q_cnt - 2'd1;
                default: q_cnt <= q_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (q_push) q_hdr[q_wr] <= reply_hdr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            out_valid <= 1'b0;
            byte_idx  <= '0;
            first_pay <= 1'b0;
            led       <= '0;
        end else begin
            out_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (q_pop) begin
                        state    <= S_HDR;
                        byte_idx <= '0;
                    end
                end
                S_HDR: begin
                    out_valid <= 1'b1;
                    byte_idx  <= byte_idx + 6'd1;
                    if (hdr_end) begin
                        // Reply without payload ends on the header
                        state     <= no_pay ? S_IDLE : S_PAY;
                        first_pay <= 1'b1;
                    end
                end
                S_PAY: begin
                    if (fifo_pop) begin
                        out_valid <= 1'b1;
                        first_pay <= 1'b0;
                        if (first_pay) led <= fifo_beat.data;
                        if (fifo_beat.last) state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Header goes out top byte first
    always_ff @(posedge clk) begin
        if (q_pop) begin
            cur_hdr <= q_hdr[q_rd];
            no_pay  <= q_hdr[q_rd].udp.length <= 16'(UDP_HDR_BYTES);
        end else if (state == S_HDR) begin
            cur_hdr <= frame_hdr_t'(cur_hdr << 8);
        end
        if (state == S_HDR) begin
            out_beat.data <= cur_hdr[$bits(frame_hdr_t)-1 -: 8];
            out_beat.last <= no_pay && hdr_end;
        end else if (fifo_pop) begin
            out_beat <= fifo_beat;
        end
    end

endmodule

`default_nettype wire

// File: design/udp_echo_top.sv
`timescale 1ns/1ps
`default_nettype none

module udp_echo_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  eth_pkg::byte_beat_t in_beat,
    output logic                out_valid,
    output eth_pkg::byte_beat_t out_beat,
    output logic [7:0]          led
);
    import eth_pkg::*;

    logic       hdr_valid;
    frame_hdr_t hdr;
    logic       pay_valid;
    byte_beat_t pay_beat;

    logic       echo_valid;
    frame_hdr_t echo_hdr;
    logic       fwd_valid;
    byte_beat_t fwd_beat;

    logic       reply_valid;
    frame_hdr_t reply_hdr;

    byte_beat_t fifo_beat;
    logic       fifo_empty;
    logic       fifo_pop;

    frame_header_parser u_parser (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_beat(in_beat),
        .hdr_valid(hdr_valid), .hdr(hdr),
        .pay_valid(pay_valid), .pay_beat(pay_beat)
    );

    echo_filter u_filter (
        .clk(clk), .rst(rst),
        .hdr_valid(hdr_valid), .hdr(hdr),
        .pay_valid(pay_valid), .pay_beat(pay_beat),
        .echo_valid(echo_valid), .echo_hdr(echo_hdr),
        .fwd_valid(fwd_valid), .fwd_beat(fwd_beat)
    );

    reply_header_builder u_builder (
        .clk(clk), .rst(rst),
        .echo_valid(echo_valid), .echo_hdr(echo_hdr),
        .reply_valid(reply_valid), .reply_hdr(reply_hdr)
    );

    // Holds payload while the reply header goes out
    payload_fifo u_fifo (
        .clk(clk), .rst(rst),
        .wr_valid(fwd_valid), .wr_beat(fwd_beat),
        .rd_pop(fifo_pop), .rd_beat(fifo_beat), .empty(fifo_empty)
    );

    frame_serializer u_serializer (
        .clk(clk), .rst(rst),
        .reply_valid(reply_valid), .reply_hdr(reply_hdr),
        .fifo_beat(fifo_beat), .fifo_empty(fifo_empty), .fifo_pop(fifo_pop),
        .out_valid(out_valid), .out_beat(out_beat), .led(led)
    );

endmodule

`default_nettype wire

// File: dv/frame_serializer_props.sv
`timescale 1ns/1ps
`default_nettype none

module frame_serializer_props (
    input logic                clk,
    input logic                rst,
    input logic                out_valid,
    input eth_pkg::byte_beat_t out_beat,
    input logic                fifo_pop
);
    import eth_pkg::*;

    // Beats of the current reply already sent, held once the header is out
    logic [5:0] hdr_sent;

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_sent <= '0;
        end else if (out_valid) begin
            if (out_beat.last) begin
                hdr_sent <= '0;
            end else if (hdr_sent != 6'(HDR_BYTES)) begin
                hdr_sent <= hdr_sent + 6'd1;
            end
        end
    end

    a_quiet_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !out_valid)
        else $error("out_valid high while in reset");

    // Once a reply has started, the rest of its header follows without a gap
    a_hdr_consecutive: assert property (@(posedge clk) disable iff (rst)
        hdr_sent != '0 && hdr_sent < 6'(HDR_BYTES) |-> out_valid)
        else $error("gap between reply header bytes");

    // A popped beat goes out only after all header bytes of its reply
    a_pop_after_hdr: assert property (@(posedge clk) disable iff (rst)
        fifo_pop |=> hdr_sent == 6'(HDR_BYTES))
        else $error("payload FIFO popped before the reply header was sent");

endmodule

bind frame_serializer frame_serializer_props u_props (
    .clk(clk), .rst(rst), .out_valid(out_valid), .out_beat(out_beat),
    .fifo_pop(fifo_pop)
);

`default_nettype wire

// File: dv/udp_echo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module udp_echo_tb;
    import eth_pkg::*;
    import echo_cfg_pkg::*;

    localparam int HDR_TOP = 8 * HDR_BYTES - 1;

    logic        clk;
    logic        rst;
    logic        in_valid;
    byte_beat_t  in_beat;
    logic        out_valid;
    byte_beat_t  out_beat;
    logic [7:0]  led;

    int unsigned seed = 56;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    int          total_bytes;
    int          cycles;
    int          exp_lasts;
    int          lasts_seen;
    logic [7:0]  exp_led;
    logic [7:0]  pay[$];
    byte_beat_t  exp_q[$];
    byte_beat_t  got_q[$];

    udp_echo_top UUT (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_beat(in_beat),
        .out_valid(out_valid), .out_beat(out_beat), .led(led)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Output monitor, sampled away from the active edge
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            got_q.push_back(out_beat);
            if (out_beat.last) lasts_seen++;
        end
    end

    // Limit grows with every byte sent
    always @(posedge clk) begin
        cycles++;
        if (cycles > 2 * total_bytes + 2000) begin
            $display("Run timed out after %0d cycles waiting for replies", cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {16'd0, seed[31:16]};
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string msg);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s (got %0h, expected %0h)", $time, msg, got, exp);
            errors++;
        end
    endtask

    // Header that matches this node, random elsewhere
    function automatic frame_hdr_t make_header(input int plen);
        frame_hdr_t h;
        h.eth.dst_mac     = LOCAL_MAC;
        h.eth.src_mac     = {16'(lcg_next()), 16'(lcg_next()), 16'(lcg_next())};
        h.eth.ethertype   = ETHERTYPE_IPV4;
        h.ip.version      = IP_VERSION4;
        h.ip.ihl          = IP_IHL_MIN;
        h.ip.dscp         = 6'(lcg_next());
        h.ip.ecn          = 2'(lcg_next());
        h.ip.length       = 16'(28 + plen);
        h.ip.ident        = 16'(lcg_next());
        h.ip.flags        = 3'b010;
        h.ip.frag_offset  = '0;
        h.ip.ttl          = 8'(lcg_next());
        h.ip.protocol     = IP_PROTO_UDP;
        h.ip.checksum     = 16'(lcg_next());
        h.ip.src_ip       = {16'(lcg_next()), 16'(lcg_next())};
        h.ip.dst_ip       = LOCAL_IP;
        h.udp.src_port    = 16'(lcg_next());
        h.udp.dst_port    = ECHO_PORT;
        h.udp.length      = 16'(8 + plen);
        h.udp.checksum    = 16'(lcg_next());
        return h;
    endfunction

    // Expected reply header, checksum summed pair of bytes at a time
    function automatic frame_hdr_t reply_of(input frame_hdr_t h);
        frame_hdr_t   r;
        logic [159:0] ip_bits;
        logic [31:0]  sum;
        r = h;
        r.eth.dst_mac    = h.eth.src_mac;
        r.eth.src_mac    = h.eth.dst_mac;
        r.ip.dscp        = '0;
        r.ip.ecn         = '0;
        r.ip.ident       = '0;
        r.ip.flags       = '0;
        r.ip.frag_offset = '0;
        r.ip.ttl         = 8'd64;
        r.ip.checksum    = '0;
        r.ip.src_ip      = h.ip.dst_ip;
        r.ip.dst_ip      = h.ip.src_ip;
        r.udp.src_port   = h.udp.dst_port;
        r.udp.dst_port   = h.udp.src_port;
        r.udp.checksum   = '0;
        ip_bits = r.ip;
        sum = '0;
        for (int i = 0; i < 20; i += 2) begin
            sum = sum + {16'd0, ip_bits[159 - 8*i -: 8], ip_bits[151 - 8*i -: 8]};
        end
        while (sum > 32'hFFFF) sum = (sum & 32'hFFFF) + (sum >> 16);
        r.ip.checksum = ~sum[15:0];
        return r;
    endfunction

    // cut > 0 stops the frame early with last on that byte
    task automatic send_frame(input frame_hdr_t h, input int plen, input int cut,
                              input int gap_max, input bit echoed);
        logic [7:0] bytes[$];
        frame_hdr_t r;
        int         n;
        int         gaps;
        pay.delete();
        for (int i = 0; i < HDR_BYTES; i++) bytes.push_back(h[HDR_TOP - 8*i -: 8]);
        for (int i = 0; i < plen; i++) begin
            pay.push_back(8'(lcg_next()));
            bytes.push_back(pay[i]);
        end
        n = (cut > 0) ? cut : bytes.size();
        total_bytes += n;
        for (int i = 0; i < n; i++) begin
            gaps = (gap_max > 0) ? int'(lcg_next() % (gap_max + 1)) : 0;
            repeat (gaps) begin
                @(negedge clk);
                in_valid = 1'b0;
            end
            @(negedge clk);
            in_valid     = 1'b1;
            in_beat.data = bytes[i];
            in_beat.last = (i == n - 1);
        end
        if (echoed) begin
            r = reply_of(h);
            for (int i = 0; i < HDR_BYTES; i++) exp_q.push_back({r[HDR_TOP - 8*i -: 8], 1'b0});
            for (int i = 0; i < plen; i++) exp_q.push_back({pay[i], i == plen - 1});
            exp_lasts++;
            exp_led = pay[0];
        end
    endtask

    task automatic drain_and_compare(input string name);
        @(negedge clk);
        in_valid = 1'b0;
        while (lasts_seen < exp_lasts) @(negedge clk);
        // Room for any stray reply to show up
        repeat (50) @(negedge clk);
        check_value(got_q.size(), exp_q.size(), {name, ": reply byte count"});
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            check_value({23'd0, got_q[i]}, {23'd0, exp_q[i]},
                        $sformatf("%s: reply byte %0d", name, i));
        end
        check_value({24'd0, led}, {24'd0, exp_led}, {name, ": led"});
        got_q.delete();
        exp_q.delete();
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic led_tracks_replies();
        int e;
        e = errors;
        check_value({24'd0, led}, 32'd0, "led after reset");
        send_frame(make_header(5), 5, 0, 0, 1'b1);
        drain_and_compare("led tracking 1");
        send_frame(make_header(9), 9, 0, 0, 1'b1);
        drain_and_compare("led tracking 2");
        report_test("led tracking", e);
    endtask

    task automatic single_echo();
        int         e;
        int         plen;
        frame_hdr_t h;
        e = errors;
        plen = 1 + int'(lcg_next() % 64);
        h = make_header(plen);
        send_frame(h, plen, 0, 0, 1'b1);
        drain_and_compare("single echo");
        report_test("single echo", e);
    endtask

    task automatic filter_rejects();
        int         e;
        frame_hdr_t h;
        e = errors;
        h = make_header(8);
        h.udp.dst_port = ECHO_PORT + 16'd1;
        send_frame(h, 8, 0, 0, 1'b0);
        h = make_header(8);
        h.ip.dst_ip = LOCAL_IP ^ 32'h1;
        send_frame(h, 8, 0, 0, 1'b0);
        h = make_header(8);
        h.eth.ethertype = 16'h86DD;
        send_frame(h, 8, 0, 0, 1'b0);
        h = make_header(8);
        h.ip.protocol = 8'd6;
        send_frame(h, 8, 0, 0, 1'b0);
        send_frame(make_header(16), 16, 0, 0, 1'b1);
        drain_and_compare("filter rejects");
        report_test("filter rejects", e);
    endtask

    task automatic truncated_header();
        int e;
        e = errors;
        send_frame(make_header(12), 12, 20, 0, 1'b0);
        send_frame(make_header(12), 12, 0, 0, 1'b1);
        drain_and_compare("truncated header");
        report_test("truncated header", e);
    endtask

    task automatic back_to_back_echo();
        int         e;
        int         plen;
        frame_hdr_t h;
        e = errors;
        for (int k = 0; k < 5; k++) begin
            plen = 1 + int'(lcg_next() % 64);
            h = make_header(plen);
            send_frame(h, plen, 0, (k % 2 == 1) ? 2 : 0, 1'b1);
        end
        drain_and_compare("back to back");
        report_test("back to back", e);
    endtask

    initial begin
        rst     = 1'b1;
        in_valid = 1'b0;
        in_beat  = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        led_tracks_replies();
        single_echo();
        filter_rejects();
        truncated_header();
        back_to_back_echo();
        $display("Tests passed: %0d, failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
design/eth_pkg.sv
design/echo_cfg_pkg.sv
design/frame_header_parser.sv
design/echo_filter.sv
design/reply_header_builder.sv
design/payload_fifo.sv
design/frame_serializer.sv
design/udp_echo_top.sv
dv/frame_serializer_props.sv
dv/udp_echo_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the UDP echo testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module udp_echo_tb -f verilog.f \
    --Mdir obj_dir -o sim_udp_echo

# The simulator may stop early on an assertion, so the log decides
./obj_dir/sim_udp_echo > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log || ! grep -q "Test passed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
